// File: filelist.f
+incdir+.
rv_core_pkg.sv
reg_file.sv
id_stage.sv
id_ex.sv
ex_stage.sv
dec_ex_top.sv
tb_dec_ex.sv

// File: Bender.yml
package:
  name: dec_ex_slice

sources:
  - include_dirs:
      - .
    files:
      - rv_core_pkg.sv
      - reg_file.sv
      - id_stage.sv
      - id_ex.sv
      - ex_stage.sv
      - dec_ex_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dec_ex.sv

// File: tb_dec_ex.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defines.svh"

module tb_dec_ex;
  import rv_core_pkg::*;

  localparam realtime CLK_PERIOD = 4.0;
  localparam int      RND        = -1;   // stall burst drawn at build time

  localparam logic [2:0] F3_ADD = 3'd0;
  localparam logic [2:0] F3_SLL = 3'd1;
  localparam logic [2:0] F3_SLT = 3'd2;
  localparam logic [2:0] F3_XOR = 3'd4;
  localparam logic [2:0] F3_SRL = 3'd5;
  localparam logic [2:0] F3_OR  = 3'd6;
  localparam logic [2:0] F3_AND = 3'd7;
  localparam logic [2:0] F3_BEQ = 3'd0;
  localparam logic [2:0] F3_BNE = 3'd1;

  logic     clk;
  logic     rst_n_i;
  logic     stall_i;
  logic     inst_valid_i;
  logic     inst_ready_o;
  inst_t    inst_i;
  xlen_t    inst_addr_i;
  logic     retire_valid_o;
  reg_idx_t retire_rd_o;
  xlen_t    retire_data_o;
  logic     retire_illegal_o;
  logic     redirect_o;
  xlen_t    redirect_addr_o;

  // stimulus and expectation table as parallel queues
  inst_t    row_inst[$];
  xlen_t    row_addr[$];
  int       row_stall[$];
  bit       row_valid[$];
  reg_idx_t row_rd[$];
  xlen_t    row_data[$];
  bit       row_ill[$];
  bit       row_redir[$];
  xlen_t    row_target[$];
  bit       row_drop[$];

  int       expect_q[$];   // rows that show up at the retire ports
  xlen_t    build_pc;
  xlen_t    jump_target;
  int       budget_cycles = 0;
  int       seed_val;

  dec_ex_top UUT (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .stall_i          (stall_i),
    .inst_valid_i     (inst_valid_i),
    .inst_ready_o     (inst_ready_o),
    .inst_i           (inst_i),
    .inst_addr_i      (inst_addr_i),
    .retire_valid_o   (retire_valid_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o),
    .redirect_o       (redirect_o),
    .redirect_addr_o  (redirect_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_field(input string where, input string name,
                             input xlen_t got, input xlen_t exp);
    assert (got === exp) else begin
      $display("MISMATCH %s %s: got 0x%0h expected 0x%0h", name, where, got, exp);
      stop_run();
    end
  endtask

  // isa encoders
  function automatic inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_idx_t rd, input reg_idx_t rs1,
                                   input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic inst_t i_type(input logic [2:0] f3, input reg_idx_t rd,
                                   input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic inst_t lui(input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic inst_t branch(input logic [2:0] f3, input reg_idx_t rs1,
                                   input reg_idx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic inst_t jal(input reg_idx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_row(input inst_t inst, input int stall, input bit exp_valid,
                         input reg_idx_t rd, input xlen_t data, input bit exp_ill,
                         input bit exp_redir, input xlen_t target, input bit drop);
    row_inst.push_back(inst);
    row_addr.push_back(build_pc);
    row_stall.push_back((stall == RND) ? 1 + int'($urandom % 4) : stall);
    row_valid.push_back(exp_valid);
    row_rd.push_back(rd);
    row_data.push_back(data);
    row_ill.push_back(exp_ill);
    row_redir.push_back(exp_redir);
    row_target.push_back(target);
    row_drop.push_back(drop);
    build_pc += 4;
  endtask

  task automatic put_wr(input inst_t inst, input int stall, input reg_idx_t rd,
                        input xlen_t data);
    add_row(inst, stall, 1'b1, rd, data, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic put_quiet(input inst_t inst, input int stall);
    add_row(inst, stall, 1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic put_jump(input inst_t inst, input int stall, input reg_idx_t rd,
                          input xlen_t data, input xlen_t target);
    add_row(inst, stall, rd != '0, rd, data, 1'b0, 1'b1, target, 1'b0);
    jump_target = target;
  endtask

  // wrong-path slot before fetch resumes at the jump target
  task automatic put_drop(input inst_t inst);
    add_row(inst, 0, 1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b1);
    build_pc = jump_target;
  endtask

  task automatic put_illegal(input inst_t inst, input int stall);
    add_row(inst, stall, 1'b0, '0, '0, 1'b1, 1'b0, '0, 1'b0);
  endtask

  task automatic build_table();
    int total_stall;
    total_stall = 0;
    build_pc = 32'h0000_0100;
    put_wr(i_type(F3_ADD, 1, 0, 5), 0, 1, 32'h0000_0005);
    put_wr(r_type(7'h00, F3_ADD, 2, 1, 1), 0, 2, 32'h0000_000a);   // bypass
    put_wr(i_type(F3_ADD, 3, 0, -3), 0, 3, 32'hffff_fffd);
    put_wr(r_type(7'h20, F3_ADD, 4, 1, 3), RND, 4, 32'h0000_0008);
    put_wr(i_type(F3_ADD, 5, 0, 12'h0f0), 0, 5, 32'h0000_00f0);
    put_wr(i_type(F3_ADD, 6, 0, 12'h0cc), 0, 6, 32'h0000_00cc);
    put_wr(r_type(7'h00, F3_AND, 7, 5, 6), 2, 7, 32'h0000_00c0);
    put_wr(r_type(7'h00, F3_OR, 8, 5, 6), 0, 8, 32'h0000_00fc);
    put_wr(r_type(7'h00, F3_XOR, 9, 5, 6), 0, 9, 32'h0000_003c);
    put_wr(r_type(7'h00, F3_SLT, 10, 3, 1), 0, 10, 32'h0000_0001);
    put_wr(r_type(7'h00, F3_SLT, 11, 1, 3), 0, 11, 32'h0000_0000);
    put_wr(i_type(F3_ADD, 12, 0, -8), 0, 12, 32'hffff_fff8);
    put_wr(r_type(7'h00, F3_SLT, 13, 12, 3), RND, 13, 32'h0000_0001);   // -8 < -3
    put_wr(r_type(7'h00, F3_SLL, 14, 1, 1), 0, 14, 32'h0000_00a0);
    put_wr(r_type(7'h00, F3_SRL, 15, 3, 1), 0, 15, 32'h07ff_ffff);
    put_wr(i_type(F3_AND, 16, 3, 12'h00f), 0, 16, 32'h0000_000d);
    put_wr(i_type(F3_OR, 17, 1, 12'h700), 3, 17, 32'h0000_0705);
    put_wr(i_type(F3_XOR, 18, 1, -1), 0, 18, 32'hffff_fffa);
    put_wr(i_type(F3_SLT, 19, 3, -2), 0, 19, 32'h0000_0001);
    put_wr(i_type(F3_SLT, 20, 1, 4), 0, 20, 32'h0000_0000);
    put_wr(lui(21, 20'habcde), 0, 21, 32'habcd_e000);
    put_quiet(i_type(F3_ADD, 0, 1, 7), 0);   // x0 write is silent
    put_wr(r_type(7'h00, F3_ADD, 22, 0, 1), 0, 22, 32'h0000_0005);
    put_quiet(branch(F3_BEQ, 1, 2, 8), 0);   // not taken
    put_jump(branch(F3_BNE, 1, 2, 12), 0, 0, '0, 32'h0000_016c);
    put_drop(i_type(F3_ADD, 23, 0, 1));
    put_wr(i_type(F3_ADD, 24, 0, 2), 0, 24, 32'h0000_0002);
    put_jump(branch(F3_BEQ, 1, 22, 16), 0, 0, '0, 32'h0000_0180);
    put_drop(i_type(F3_ADD, 25, 0, 3));
    row_stall[row_stall.size() - 1] = 1 + int'($urandom % 4);   // stall ahead of a drop
    put_quiet(branch(F3_BNE, 1, 22, 8), 0);
    put_jump(jal(26, 21'h00020), 0, 26, 32'h0000_0188, 32'h0000_01a4);
    put_drop(i_type(F3_ADD, 27, 0, 9));
    put_wr(r_type(7'h00, F3_ADD, 28, 26, 1), RND, 28, 32'h0000_018d);
    put_jump(jal(0, -8), 0, 0, '0, 32'h0000_01a0);
    put_drop(i_type(F3_ADD, 29, 0, 1));
    put_illegal(32'h0000_008b, 0);   // custom-0 opcode with rd field x1
    put_wr(r_type(7'h00, F3_ADD, 30, 1, 0), 0, 30, 32'h0000_0005);
    put_illegal(r_type(7'h20, F3_SRL, 1, 1, 1), RND);   // sra not in subset
    put_wr(i_type(F3_ADD, 31, 1, 0), 0, 31, 32'h0000_0005);
    for (int i = 0; i < row_inst.size(); i++) begin
      total_stall += row_stall[i];
      if (row_valid[i] || row_ill[i] || row_redir[i]) begin
        expect_q.push_back(i);
      end
    end
    budget_cycles = row_inst.size() + total_stall + 20;
  endtask

  task automatic run_rows();
    bit settled;
    bit dropped;
    for (int i = 0; i < row_inst.size(); i++) begin
      inst_valid_i <= 1'b1;
      inst_i       <= row_inst[i];
      inst_addr_i  <= row_addr[i];
      if (row_stall[i] > 0) begin
        stall_i <= 1'b1;   // row waits behind the burst
        repeat (row_stall[i]) begin
          @(negedge clk);
          check_field($sformatf("stall before row %0d", i), "inst_ready_o",
                      inst_ready_o, 1'b0);
          @(posedge clk);
        end
        stall_i <= 1'b0;
      end
      settled = 1'b0;
      dropped = 1'b0;
      while (!settled) begin
        @(negedge clk);
        if (inst_ready_o) begin
          settled = 1'b1;
        end else if (redirect_o) begin
          dropped = 1'b1;   // source drops the wrong-path word
          settled = 1'b1;
        end
        @(posedge clk);
      end
      assert (dropped == row_drop[i]) else begin
        $display("row %0d at 0x%0h was %s", i, row_addr[i],
                 dropped ? "refused during a redirect although it is on the right path"
                         : "accepted although it sits on the wrong path of a redirect");
        stop_run();
      end
    end
    inst_valid_i <= 1'b0;
  endtask

  always @(negedge clk) begin : retire_monitor
    int    idx;
    string where;
    if (retire_valid_o || retire_illegal_o || redirect_o) begin
      assert (expect_q.size() > 0) else begin
        $display("retire port activity seen after every expected row has retired");
        stop_run();
      end
      idx   = expect_q.pop_front();
      where = $sformatf("row %0d", idx);
      check_field(where, "retire_valid_o", retire_valid_o, row_valid[idx]);
      check_field(where, "retire_illegal_o", retire_illegal_o, row_ill[idx]);
      check_field(where, "redirect_o", redirect_o, row_redir[idx]);
      if (row_redir[idx]) begin
        check_field(where, "redirect_addr_o", redirect_addr_o, row_target[idx]);
      end
      if (row_valid[idx]) begin
        check_field(where, "retire_rd_o", retire_rd_o, row_rd[idx]);
        check_field(where, "retire_data_o", retire_data_o, row_data[idx]);
      end
    end
  end

  initial begin
    wait (budget_cycles > 0);
    #(budget_cycles * CLK_PERIOD);
    $display("timeout, the run did not finish within %0d clock cycles", budget_cycles);
    stop_run();
  end

  initial begin
    rst_n_i      = 1'b0;
    stall_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = `INST_NOP;
    inst_addr_i  = '0;
    seed_val     = $urandom(65);
    build_table();
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_field("after reset", "inst_ready_o", inst_ready_o, 1'b1);
    repeat (3) @(posedge clk);   // idle with valid low
    run_rows();
    repeat (4) @(posedge clk);
    if (expect_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("%0d expected retire events never appeared, first is row %0d",
               expect_q.size(), expect_q[0]);
      stop_run();
    end
  end

endmodule

`default_nettype wire

// File: dec_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module dec_ex_top (
  input  wire                        clk,
  input  wire                        rst_n_i,
  input  wire                        stall_i,
  input  wire                        inst_valid_i,
  output logic                       inst_ready_o,
  input  wire rv_core_pkg::inst_t    inst_i,
  input  wire rv_core_pkg::xlen_t    inst_addr_i,
  output logic                       retire_valid_o,
  output rv_core_pkg::reg_idx_t      retire_rd_o,
  output rv_core_pkg::xlen_t         retire_data_o,
  output logic                       retire_illegal_o,
  output logic                       redirect_o,
  output rv_core_pkg::xlen_t         redirect_addr_o
);
  import rv_core_pkg::*;

  logic     accept;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  xlen_t    rs1_data;
  xlen_t    rs2_data;

  logic     id_valid;
  xlen_t    id_pc;
  reg_idx_t id_rd;
  logic     id_rd_wen;
  xlen_t    id_rs1_data;
  xlen_t    id_rs2_data;
  xlen_t    id_imm;
  logic     id_use_imm;
  alu_op_t  id_alu_op;
  pc_op_t   id_pc_op;
  logic     id_illegal;

  logic     ex_valid;
  xlen_t    ex_pc;
  reg_idx_t ex_rd;
  logic     ex_rd_wen;
  xlen_t    ex_rs1_data;
  xlen_t    ex_rs2_data;
  xlen_t    ex_imm;
  logic     ex_use_imm;
  alu_op_t  ex_alu_op;
  pc_op_t   ex_pc_op;
  logic     ex_illegal;

  logic     wb_en;
  reg_idx_t wb_rd;
  xlen_t    wb_data;

  // wrong-path instruction is refused while redirecting
  assign inst_ready_o = !stall_i && !redirect_o;
  assign accept       = inst_valid_i && inst_ready_o;

  reg_file u_reg_file (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_en_i    (wb_en),
    .wb_rd_i    (wb_rd),
    .wb_data_i  (wb_data)
  );

  id_stage u_id_stage (
    .inst_valid_i  (inst_valid_i),
    .inst_ready_i  (inst_ready_o),
    .inst_i        (inst_i),
    .inst_addr_i   (inst_addr_i),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .id_valid_o    (id_valid),
    .id_pc_o       (id_pc),
    .id_rd_o       (id_rd),
    .id_rd_wen_o   (id_rd_wen),
    .id_rs1_data_o (id_rs1_data),
    .id_rs2_data_o (id_rs2_data),
    .id_imm_o      (id_imm),
    .id_use_imm_o  (id_use_imm),
    .id_alu_op_o   (id_alu_op),
    .id_pc_op_o    (id_pc_op),
    .id_illegal_o  (id_illegal)
  );

  id_ex u_id_ex (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .accept_i      (accept),
    .id_valid_i    (id_valid),
    .id_pc_i       (id_pc),
    .id_rd_i       (id_rd),
    .id_rd_wen_i   (id_rd_wen),
    .id_rs1_data_i (id_rs1_data),
    .id_rs2_data_i (id_rs2_data),
    .id_imm_i      (id_imm),
    .id_use_imm_i  (id_use_imm),
    .id_alu_op_i   (id_alu_op),
    .id_pc_op_i    (id_pc_op),
    .id_illegal_i  (id_illegal),
    .ex_valid_o    (ex_valid),
    .ex_pc_o       (ex_pc),
    .ex_rd_o       (ex_rd),
    .ex_rd_wen_o   (ex_rd_wen),
    .ex_rs1_data_o (ex_rs1_data),
    .ex_rs2_data_o (ex_rs2_data),
    .ex_imm_o      (ex_imm),
    .ex_use_imm_o  (ex_use_imm),
    .ex_alu_op_o   (ex_alu_op),
    .ex_pc_op_o    (ex_pc_op),
    .ex_illegal_o  (ex_illegal)
  );

  ex_stage u_ex_stage (
    .stall_i          (stall_i),
    .ex_valid_i       (ex_valid),
    .ex_pc_i          (ex_pc),
    .ex_rd_i          (ex_rd),
    .ex_rd_wen_i      (ex_rd_wen),
    .ex_rs1_data_i    (ex_rs1_data),
    .ex_rs2_data_i    (ex_rs2_data),
    .ex_imm_i         (ex_imm),
    .ex_use_imm_i     (ex_use_imm),
    .ex_alu_op_i      (ex_alu_op),
    .ex_pc_op_i       (ex_pc_op),
    .ex_illegal_i     (ex_illegal),
    .wb_en_o          (wb_en),
    .wb_rd_o          (wb_rd),
    .wb_data_o        (wb_data),
    .retire_valid_o   (retire_valid_o),
    .retire_illegal_o (retire_illegal_o),
    .redirect_o       (redirect_o),
    .redirect_addr_o  (redirect_addr_o)
  );

  assign retire_rd_o   = wb_rd;
  assign retire_data_o = wb_data;

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  wire                         stall_i,
  input  wire                         ex_valid_i,
  input  wire rv_core_pkg::xlen_t     ex_pc_i,
  input  wire rv_core_pkg::reg_idx_t  ex_rd_i,
  input  wire                         ex_rd_wen_i,
  input  wire rv_core_pkg::xlen_t     ex_rs1_data_i,
  input  wire rv_core_pkg::xlen_t     ex_rs2_data_i,
  input  wire rv_core_pkg::xlen_t     ex_imm_i,
  input  wire                         ex_use_imm_i,
  input  wire rv_core_pkg::alu_op_t   ex_alu_op_i,
  input  wire rv_core_pkg::pc_op_t    ex_pc_op_i,
  input  wire                         ex_illegal_i,
  output logic                        wb_en_o,
  output rv_core_pkg::reg_idx_t       wb_rd_o,
  output rv_core_pkg::xlen_t          wb_data_o,
  output logic                        retire_valid_o,
  output logic                        retire_illegal_o,
  output logic                        redirect_o,
  output rv_core_pkg::xlen_t          redirect_addr_o
);
  import rv_core_pkg::*;

  xlen_t op_b;
  xlen_t alu_res;
  xlen_t link_addr;
  xlen_t target;
  xlen_t result;
  logic  fire;
  logic  taken;

  assign fire = ex_valid_i && !stall_i;   // retire once, after stall drops
  assign op_b = ex_use_imm_i ? ex_imm_i : ex_rs2_data_i;

  always_comb begin
    case (ex_alu_op_i)
      ALU_ADD:   alu_res = ex_rs1_data_i + op_b;
      ALU_SUB:   alu_res = ex_rs1_data_i - op_b;
      ALU_AND:   alu_res = ex_rs1_data_i & op_b;
      ALU_OR:    alu_res = ex_rs1_data_i | op_b;
      ALU_XOR:   alu_res = ex_rs1_data_i ^ op_b;
      ALU_SLT:   alu_res = xlen_t'($signed(ex_rs1_data_i) < $signed(op_b));
      ALU_SLL:   alu_res = ex_rs1_data_i << op_b[4:0];
      ALU_SRL:   alu_res = ex_rs1_data_i >> op_b[4:0];
      ALU_PASSB: alu_res = op_b;
      default:   alu_res = '0;
    endcase
  end

  assign link_addr = ex_pc_i + xlen_t'(4);
  assign target    = ex_pc_i + ex_imm_i;

  always_comb begin
    case (ex_pc_op_i)
      PC_BEQ:  taken = (ex_rs1_data_i == ex_rs2_data_i);
      PC_BNE:  taken = (ex_rs1_data_i != ex_rs2_data_i);
      PC_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign result = (ex_pc_op_i == PC_JAL) ? link_addr : alu_res;

  assign wb_en_o   = fire && ex_rd_wen_i;
  assign wb_rd_o   = fire ? ex_rd_i : '0;
  assign wb_data_o = fire ? result : '0;

  assign retire_valid_o   = wb_en_o;   // only register writes are reported
  assign retire_illegal_o = fire && ex_illegal_i;

  assign redirect_o      = fire && taken;
  assign redirect_addr_o = redirect_o ? target : '0;

endmodule

`default_nettype wire

// File: id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex (
  input  wire                         clk,
  input  wire                         rst_n_i,
  input  wire                         stall_i,
  input  wire                         accept_i,
  input  wire                         id_valid_i,
  input  wire rv_core_pkg::xlen_t     id_pc_i,
  input  wire rv_core_pkg::reg_idx_t  id_rd_i,
  input  wire                         id_rd_wen_i,
  input  wire rv_core_pkg::xlen_t     id_rs1_data_i,
  input  wire rv_core_pkg::xlen_t     id_rs2_data_i,
  input  wire rv_core_pkg::xlen_t     id_imm_i,
  input  wire                         id_use_imm_i,
  input  wire rv_core_pkg::alu_op_t   id_alu_op_i,
  input  wire rv_core_pkg::pc_op_t    id_pc_op_i,
  input  wire                         id_illegal_i,
  output logic                        ex_valid_o,
  output rv_core_pkg::xlen_t          ex_pc_o,
  output rv_core_pkg::reg_idx_t       ex_rd_o,
  output logic                        ex_rd_wen_o,
  output rv_core_pkg::xlen_t          ex_rs1_data_o,
  output rv_core_pkg::xlen_t          ex_rs2_data_o,
  output rv_core_pkg::xlen_t          ex_imm_o,
  output logic                        ex_use_imm_o,
  output rv_core_pkg::alu_op_t        ex_alu_op_o,
  output rv_core_pkg::pc_op_t         ex_pc_op_o,
  output logic                        ex_illegal_o
);
  import rv_core_pkg::*;

  // stall holds everything, otherwise load the accepted instruction or a bubble
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_o    <= 1'b0;
      ex_pc_o       <= '0;
      ex_rd_o       <= '0;
      ex_rd_wen_o   <= 1'b0;
      ex_rs1_data_o <= '0;
      ex_rs2_data_o <= '0;
      ex_imm_o      <= '0;
      ex_use_imm_o  <= 1'b0;
      ex_alu_op_o   <= ALU_NONE;
      ex_pc_op_o    <= PC_NONE;
      ex_illegal_o  <= 1'b0;
    end else if (!stall_i) begin
      ex_valid_o    <= accept_i && id_valid_i;
      ex_pc_o       <= accept_i ? id_pc_i : '0;
      ex_rd_o       <= accept_i ? id_rd_i : '0;
      ex_rd_wen_o   <= accept_i && id_rd_wen_i;
      ex_rs1_data_o <= accept_i ? id_rs1_data_i : '0;
      ex_rs2_data_o <= accept_i ? id_rs2_data_i : '0;
      ex_imm_o      <= accept_i ? id_imm_i : '0;
      ex_use_imm_o  <= accept_i && id_use_imm_i;
      ex_alu_op_o   <= accept_i ? id_alu_op_i : ALU_NONE;
      ex_pc_op_o    <= accept_i ? id_pc_op_i : PC_NONE;
      ex_illegal_o  <= accept_i && id_illegal_i;
    end
  end

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  wire                        inst_valid_i,
  input  wire                        inst_ready_i,
  input  wire rv_core_pkg::inst_t    inst_i,
  input  wire rv_core_pkg::xlen_t    inst_addr_i,
  output rv_core_pkg::reg_idx_t      rs1_idx_o,
  output rv_core_pkg::reg_idx_t      rs2_idx_o,
  input  wire rv_core_pkg::xlen_t    rs1_data_i,
  input  wire rv_core_pkg::xlen_t    rs2_data_i,
  output logic                       id_valid_o,
  output rv_core_pkg::xlen_t         id_pc_o,
  output rv_core_pkg::reg_idx_t      id_rd_o,
  output logic                       id_rd_wen_o,
  output rv_core_pkg::xlen_t         id_rs1_data_o,
  output rv_core_pkg::xlen_t         id_rs2_data_o,
  output rv_core_pkg::xlen_t         id_imm_o,
  output logic                       id_use_imm_o,
  output rv_core_pkg::alu_op_t       id_alu_op_o,
  output rv_core_pkg::pc_op_t        id_pc_op_o,
  output logic                       id_illegal_o
);
  import rv_core_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_b;
  xlen_t      imm_j;
  logic       writes_rd;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  assign id_valid_o    = inst_valid_i && inst_ready_i;   // accept
  assign id_pc_o       = inst_addr_i;
  assign id_rd_o       = inst_i[11:7];
  assign rs1_idx_o     = inst_i[19:15];
  assign rs2_idx_o     = inst_i[24:20];
  assign id_rs1_data_o = rs1_data_i;
  assign id_rs2_data_o = rs2_data_i;

  always_comb begin
    id_alu_op_o  = ALU_NONE;
    id_pc_op_o   = PC_NONE;
    id_imm_o     = '0;
    id_use_imm_o = 1'b0;
    id_illegal_o = 1'b0;
    writes_rd    = 1'b0;
    case (opcode)
      OPC_OP: begin
        writes_rd = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: id_alu_op_o = ALU_ADD;
          {7'b0100000, 3'b000}: id_alu_op_o = ALU_SUB;
          {7'b0000000, 3'b111}: id_alu_op_o = ALU_AND;
          {7'b0000000, 3'b110}: id_alu_op_o = ALU_OR;
          {7'b0000000, 3'b100}: id_alu_op_o = ALU_XOR;
          {7'b0000000, 3'b010}: id_alu_op_o = ALU_SLT;
          {7'b0000000, 3'b001}: id_alu_op_o = ALU_SLL;
          {7'b0000000, 3'b101}: id_alu_op_o = ALU_SRL;
          default:              id_illegal_o = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        writes_rd    = 1'b1;
        id_use_imm_o = 1'b1;
        id_imm_o     = imm_i;
        case (funct3)
          3'b000:  id_alu_op_o = ALU_ADD;
          3'b111:  id_alu_op_o = ALU_AND;
          3'b110:  id_alu_op_o = ALU_OR;
          3'b100:  id_alu_op_o = ALU_XOR;
          3'b010:  id_alu_op_o = ALU_SLT;
          default: id_illegal_o = 1'b1;   // shifts, sltiu not in subset
        endcase
      end
      OPC_LUI: begin
        writes_rd    = 1'b1;
        id_use_imm_o = 1'b1;
        id_imm_o     = imm_u;
        id_alu_op_o  = ALU_PASSB;
      end
      OPC_BRANCH: begin
        id_imm_o = imm_b;
        case (funct3)
          3'b000:  id_pc_op_o = PC_BEQ;
          3'b001:  id_pc_op_o = PC_BNE;
          default: id_illegal_o = 1'b1;
        endcase
      end
      OPC_JAL: begin
        writes_rd  = 1'b1;
        id_imm_o   = imm_j;
        id_pc_op_o = PC_JAL;   // link value made in ex
      end
      default: id_illegal_o = 1'b1;
    endcase
    if (id_illegal_o) begin
      id_alu_op_o = ALU_NONE;
      id_pc_op_o  = PC_NONE;
    end
  end

  assign id_rd_wen_o = writes_rd && !id_illegal_o && (id_rd_o != '0);

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defines.svh"

module reg_file (
  input  wire                        clk,
  input  wire                        rst_n_i,
  input  wire rv_core_pkg::reg_idx_t rs1_idx_i,
  input  wire rv_core_pkg::reg_idx_t rs2_idx_i,
  output rv_core_pkg::xlen_t         rs1_data_o,
  output rv_core_pkg::xlen_t         rs2_data_o,
  input  wire                        wb_en_i,
  input  wire rv_core_pkg::reg_idx_t wb_rd_i,
  input  wire rv_core_pkg::xlen_t    wb_data_i
);
  import rv_core_pkg::*;

  localparam int NUM_REGS = 1 << `REG_ADDRWIDTH;

  xlen_t regs [NUM_REGS];   // regs[0] stays at its reset zero
  logic  wr_en;
  logic  rs1_hit;
  logic  rs2_hit;

  assign wr_en = wb_en_i && (wb_rd_i != '0);   // x0 never written

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // write-through, ex result reaches the instruction in id
  assign rs1_hit = wr_en && (wb_rd_i == rs1_idx_i);
  assign rs2_hit = wr_en && (wb_rd_i == rs2_idx_i);

  assign rs1_data_o = rs1_hit ? wb_data_i : regs[rs1_idx_i];
  assign rs2_data_o = rs2_hit ? wb_data_i : regs[rs2_idx_i];

endmodule

`default_nettype wire

// File: rv_core_pkg.sv
`default_nettype none

`include "rv_core_defines.svh"

package rv_core_pkg;

  typedef logic [`XLEN-1:0]          xlen_t;     // data or address word
  typedef logic [`REG_ADDRWIDTH-1:0] reg_idx_t;
  typedef logic [`INST_LEN-1:0]      inst_t;
  typedef logic [`ALUOP_LEN-1:0]     alu_op_t;
  typedef logic [`PCOP_LEN-1:0]      pc_op_t;

  // alu op codes
  localparam alu_op_t ALU_NONE  = alu_op_t'(0);
  localparam alu_op_t ALU_ADD   = alu_op_t'(1);
  localparam alu_op_t ALU_SUB   = alu_op_t'(2);
  localparam alu_op_t ALU_AND   = alu_op_t'(3);
  localparam alu_op_t ALU_OR    = alu_op_t'(4);
  localparam alu_op_t ALU_XOR   = alu_op_t'(5);
  localparam alu_op_t ALU_SLT   = alu_op_t'(6);   // signed
  localparam alu_op_t ALU_SLL   = alu_op_t'(7);
  localparam alu_op_t ALU_SRL   = alu_op_t'(8);
  localparam alu_op_t ALU_PASSB = alu_op_t'(9);   // lui

  // pc op codes
  localparam pc_op_t PC_NONE = pc_op_t'(0);
  localparam pc_op_t PC_BEQ  = pc_op_t'(1);
  localparam pc_op_t PC_BNE  = pc_op_t'(2);
  localparam pc_op_t PC_JAL  = pc_op_t'(3);

endpackage

`default_nettype wire

// File: rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath widths
`define XLEN            32
`define REG_ADDRWIDTH   5
`define INST_LEN        32

// addi x0, x0, 0
`define INST_NOP        32'h0000_0013

// decode op code widths
`define ALUOP_LEN       4
`define PCOP_LEN        2

`endif
